// File: verilog/drone_pkg.sv
`default_nettype none

package drone_pkg;

	localparam int rec_w        = 8;    // Stick value from the RC receiver
	localparam int angle_w      = 16;   // Attitude angle and rate command, signed
	localparam int motor_w      = 10;   // Motor rate toward the ESC
	localparam int motor_max    = 1000; // Full-scale motor rate
	localparam int stick_center = 128;  // Neutral stick position
	localparam int arm_min      = 5;    // Throttle stick below this keeps motors off
	localparam int pulse_min_us = 1000; // Shortest servo pulse, zero stick or idle motor

	// RC sticks, throttle in the top byte
	typedef struct packed {
		logic [rec_w-1:0] throttle;
		logic [rec_w-1:0] yaw;
		logic [rec_w-1:0] roll;
		logic [rec_w-1:0] pitch;
	} stick_t;

	// Measured attitude from the IMU side
	typedef struct packed {
		logic signed [angle_w-1:0] roll;
		logic signed [angle_w-1:0] pitch;
		logic signed [angle_w-1:0] yaw;
	} attitude_t;

	// Angle controller output to the mixer
	typedef struct packed {
		logic [motor_w-1:0]        throttle; // Stick x 4, unsigned
		logic signed [angle_w-1:0] yaw;
		logic signed [angle_w-1:0] roll;
		logic signed [angle_w-1:0] pitch;
	} rate_cmd_t;

	typedef struct packed {
		logic [motor_w-1:0] m1; // Front left in the X frame
		logic [motor_w-1:0] m2;
		logic [motor_w-1:0] m3;
		logic [motor_w-1:0] m4;
	} motor_rates_t;

endpackage

`default_nettype wire

// File: verilog/us_tick.sv
`timescale 1ns/1ps
`default_nettype none

module us_tick #(
	parameter int CLKS_PER_US = 38
) (
	input  logic sys_clk,
	input  logic resetn,
	output logic tick
);

	localparam int cnt_w = $clog2(CLKS_PER_US + 1);

	logic [cnt_w-1:0] cnt_q; // Counts down to zero, then reloads

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			cnt_q <= cnt_w'(CLKS_PER_US - 1);
			tick  <= 1'b0;
		end else if (cnt_q == '0) begin
			cnt_q <= cnt_w'(CLKS_PER_US - 1); // Wrap, one tick per microsecond
			tick  <= 1'b1;
		end else begin
			cnt_q <= cnt_q - 1'b1;
			tick  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/pwm_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_receiver import drone_pkg::*; (
	input  logic   sys_clk,
	input  logic   resetn,
	input  logic   us_tick,
	input  logic   throttle_pwm,
	input  logic   yaw_pwm,
	input  logic   roll_pwm,
	input  logic   pitch_pwm,
	output stick_t sticks,
	output logic   frame_valid
);

	localparam int width_w = 12; // Up to 4095 us, well past a 2 ms servo pulse

	logic [3:0]                  pwm_in;  // Channel 3 is throttle, 0 is pitch
	logic [3:0]                  meta_q;  // First synchronizer stage
	logic [3:0]                  level_q; // Synchronized level
	logic [3:0]                  prev_q;  // Level one cycle earlier
	logic [3:0]                  fall;
	logic [3:0][width_w-1:0]     width_q; // High time in microseconds
	logic [3:0][rec_w-1:0]       val_q;

	// Width to stick value, 4 us per step above the 1000 us floor
	function automatic logic [rec_w-1:0] to_stick(input logic [width_w-1:0] w);
		logic [width_w-1:0] d;
		d = w - width_w'(pulse_min_us);
		if (w < width_w'(pulse_min_us))
			return '0;
		if (d[width_w-1:2] > (2**rec_w - 1))
			return '1; // Saturate at 255
		return d[rec_w+1:2];
	endfunction

	assign pwm_in = {throttle_pwm, yaw_pwm, roll_pwm, pitch_pwm};
	assign fall   = prev_q & ~level_q;
	assign sticks = stick_t'(val_q); // Same channel order as the struct

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			meta_q      <= '0;
			level_q     <= '0;
			prev_q      <= '0;
			width_q     <= '0;
			val_q       <= '0;
			frame_valid <= 1'b0;
		end else begin
			meta_q  <= pwm_in;
			level_q <= meta_q;
			prev_q  <= level_q;
			for (int i = 0; i < 4; i++) begin
				if (fall[i]) begin
					val_q[i]   <= to_stick(width_q[i]); // Latch at end of pulse
					width_q[i] <= '0;
				end else if (!level_q[i]) begin
					width_q[i] <= '0;
				end else if (us_tick && width_q[i] != '1) begin
					width_q[i] <= width_q[i] + 1'b1; // Saturating
				end
			end
			frame_valid <= fall[3]; // Throttle comes last in a frame
		end
	end

endmodule

`default_nettype wire

// File: verilog/angle_controller.sv
`timescale 1ns/1ps
`default_nettype none

module angle_controller import drone_pkg::*; #(
	parameter int KP_SHIFT = 2
) (
	input  logic      sys_clk,
	input  logic      resetn,
	input  stick_t    sticks,
	input  logic      frame_valid,
	input  attitude_t attitude,
	input  logic      att_valid,
	output rate_cmd_t rate_cmd,
	output logic      rate_valid
);

	attitude_t               att_q;       // Latest attitude sample
	logic signed [angle_w:0] roll_err_q;  // One extra bit, target minus angle can overflow
	logic signed [angle_w:0] pitch_err_q;
	logic [rec_w-1:0]        thr_q;
	logic [rec_w-1:0]        yaw_q;
	logic                    s1_valid;

	always_ff @(posedge sys_clk) begin
		if (!resetn)
			att_q <= '0; // Level until the IMU side reports
		else if (att_valid)
			att_q <= attitude;
	end

	// Strobe pipeline
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			s1_valid   <= 1'b0;
			rate_valid <= 1'b0;
		end else begin
			s1_valid   <= frame_valid;
			rate_valid <= s1_valid; // Two cycles after frame_valid
		end
	end

	// Stage 1, angle errors
	always_ff @(posedge sys_clk) begin
		if (frame_valid) begin
			roll_err_q  <= (angle_w+1)'(int'(sticks.roll) - stick_center
				- int'(att_q.roll));
			pitch_err_q <= (angle_w+1)'(int'(sticks.pitch) - stick_center
				- int'(att_q.pitch));
			thr_q       <= sticks.throttle;
			yaw_q       <= sticks.yaw;
		end
	end

	// Stage 2, P gain as a shift, rounds toward minus infinity
	always_ff @(posedge sys_clk) begin
		if (s1_valid) begin
			rate_cmd.throttle <= motor_w'(thr_q) << 2; // 0..1020
			rate_cmd.yaw      <= angle_w'(int'(yaw_q) - stick_center); // Yaw is a rate
			rate_cmd.roll     <= angle_w'(roll_err_q >>> KP_SHIFT);
			rate_cmd.pitch    <= angle_w'(pitch_err_q >>> KP_SHIFT);
		end
	end

endmodule

`default_nettype wire

// File: verilog/motor_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module motor_mixer import drone_pkg::*; (
	input  logic         sys_clk,
	input  logic         resetn,
	input  rate_cmd_t    rate_cmd,
	input  logic         rate_valid,
	output motor_rates_t motors,
	output logic         motors_valid
);

	localparam int sum_w = angle_w + 3; // Headroom for T plus three rates

	logic signed [sum_w-1:0] t;
	logic signed [sum_w-1:0] p;
	logic signed [sum_w-1:0] r;
	logic signed [sum_w-1:0] y;
	logic signed [sum_w-1:0] s1;
	logic signed [sum_w-1:0] s2;
	logic signed [sum_w-1:0] s3;
	logic signed [sum_w-1:0] s4;
	logic                    armed;

	function automatic logic [motor_w-1:0] clamp(input logic signed [sum_w-1:0] s);
		if (s < 0)
			return '0;
		if (s > motor_max)
			return motor_w'(motor_max);
		return s[motor_w-1:0];
	endfunction

	always_comb begin
		t  = sum_w'(rate_cmd.throttle); // Unsigned, zero extended
		p  = rate_cmd.pitch;            // Sign extended
		r  = rate_cmd.roll;
		y  = rate_cmd.yaw;
		// X frame, props alternate spin direction
		s1 = t + p + r - y;
		s2 = t + p - r + y;
		s3 = t - p - r - y;
		s4 = t - p + r + y;
		// Throttle command is stick x 4
		armed = rate_cmd.throttle >= motor_w'(arm_min * 4);
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			motors       <= '0;
			motors_valid <= 1'b0;
		end else begin
			motors_valid <= rate_valid;
			if (rate_valid) begin
				motors.m1 <= armed ? clamp(s1) : '0;
				motors.m2 <= armed ? clamp(s2) : '0;
				motors.m3 <= armed ? clamp(s3) : '0;
				motors.m4 <= armed ? clamp(s4) : '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/pwm_generator.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_generator import drone_pkg::*; #(
	parameter int PWM_PERIOD_US = 2500
) (
	input  logic         sys_clk,
	input  logic         resetn,
	input  logic         us_tick,
	input  motor_rates_t motors,
	input  logic         motors_valid,
	output logic         motor_1_pwm,
	output logic         motor_2_pwm,
	output logic         motor_3_pwm,
	output logic         motor_4_pwm
);

	localparam int cnt_w = $clog2(PWM_PERIOD_US);

	logic [cnt_w-1:0]        cnt_q;     // Microseconds into the period
	logic                    period_end;
	logic                    running_q; // Set once the first period has begun
	motor_rates_t            pending_q; // Waits for the next period
	logic [3:0][motor_w-1:0] active_q;  // Index 3 is motor 1
	logic [3:0]              pwm_q;

	assign period_end = us_tick && (cnt_q == cnt_w'(PWM_PERIOD_US - 1));

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			cnt_q     <= '0;
			running_q <= 1'b0;
			pending_q <= '0;
			active_q  <= '0;
			pwm_q     <= '0;
		end else begin
			if (motors_valid)
				pending_q <= motors;
			if (period_end) begin
				cnt_q     <= '0;
				running_q <= 1'b1;
				active_q  <= pending_q; // Rates change only on a period boundary
			end else if (us_tick) begin
				cnt_q <= cnt_q + 1'b1;
			end
			for (int i = 0; i < 4; i++)
				pwm_q[i] <= running_q && (int'(cnt_q) < pulse_min_us + int'(active_q[i]));
		end
	end

	assign motor_1_pwm = pwm_q[3];
	assign motor_2_pwm = pwm_q[2];
	assign motor_3_pwm = pwm_q[1];
	assign motor_4_pwm = pwm_q[0];

endmodule

`default_nettype wire

// File: verilog/drone_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module drone_ctrl import drone_pkg::*; #(
	parameter int CLKS_PER_US   = 38,
	parameter int KP_SHIFT      = 2,
	parameter int PWM_PERIOD_US = 2500
) (
	input  logic      sys_clk,
	input  logic      resetn,
	input  logic      throttle_pwm, // RC receiver channels, asynchronous
	input  logic      yaw_pwm,
	input  logic      roll_pwm,
	input  logic      pitch_pwm,
	input  attitude_t attitude,     // From the IMU side
	input  logic      att_valid,
	output logic      motor_1_pwm,  // ESC pulses
	output logic      motor_2_pwm,
	output logic      motor_3_pwm,
	output logic      motor_4_pwm
);

	logic         us_tick;
	stick_t       sticks;
	logic         frame_valid;
	rate_cmd_t    rate_cmd;
	logic         rate_valid;
	motor_rates_t motors;
	logic         motors_valid;

	us_tick #(
		.CLKS_PER_US(CLKS_PER_US)
	) us_tick_inst (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.tick(us_tick)
	);

	pwm_receiver pwm_receiver_inst (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.us_tick(us_tick),
		.throttle_pwm(throttle_pwm),
		.yaw_pwm(yaw_pwm),
		.roll_pwm(roll_pwm),
		.pitch_pwm(pitch_pwm),
		.sticks(sticks),
		.frame_valid(frame_valid) // Once per RC frame, after throttle
	);

	angle_controller #(
		.KP_SHIFT(KP_SHIFT)
	) angle_controller_inst (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.sticks(sticks),
		.frame_valid(frame_valid),
		.attitude(attitude),
		.att_valid(att_valid),
		.rate_cmd(rate_cmd),
		.rate_valid(rate_valid)
	);

	motor_mixer motor_mixer_inst (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.rate_cmd(rate_cmd),
		.rate_valid(rate_valid),
		.motors(motors),
		.motors_valid(motors_valid)
	);

	pwm_generator #(
		.PWM_PERIOD_US(PWM_PERIOD_US)
	) pwm_generator_inst (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.us_tick(us_tick),
		.motors(motors),
		.motors_valid(motors_valid),
		.motor_1_pwm(motor_1_pwm),
		.motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm),
		.motor_4_pwm(motor_4_pwm)
	);

endmodule

`default_nettype wire

// File: tb/drone_ctrl_assert.sv
`timescale 1ns/1ps
`default_nettype none

module drone_ctrl_assert import drone_pkg::*; (
	input logic         sys_clk,
	input logic         resetn,
	input logic         us_tick,
	input logic         frame_valid,
	input logic         rate_valid,
	input logic         motors_valid,
	input motor_rates_t motors
);

	int fail_count = 0; // Failed assertions so far

	property one_cycle(s);
		@(posedge sys_clk) disable iff (!resetn) s |=> !s; // Strobe drops on the next edge
	endproperty

	a_tick_pulse: assert property (one_cycle(us_tick))
		else begin
			$error("us_tick stayed high for more than one cycle");
			fail_count++;
		end
	a_frame_pulse: assert property (one_cycle(frame_valid))
		else begin
			$error("frame_valid stayed high for more than one cycle");
			fail_count++;
		end
	a_rate_pulse: assert property (one_cycle(rate_valid))
		else begin
			$error("rate_valid stayed high for more than one cycle");
			fail_count++;
		end
	a_motors_pulse: assert property (one_cycle(motors_valid))
		else begin
			$error("motors_valid stayed high for more than one cycle");
			fail_count++;
		end

	// Two register stages in the angle controller
	a_rate_delay: assert property (@(posedge sys_clk) disable iff (!resetn)
		frame_valid |-> ##2 rate_valid)
		else begin
			$error("rate_valid did not follow frame_valid after two cycles");
			fail_count++;
		end

	a_motor_limit: assert property (@(posedge sys_clk) disable iff (!resetn)
		motors.m1 <= motor_max && motors.m2 <= motor_max
		&& motors.m3 <= motor_max && motors.m4 <= motor_max)
		else begin
			$error("A motor rate exceeds the full-scale limit");
			fail_count++;
		end

endmodule

`default_nettype wire

// File: tb/drone_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module drone_ctrl_tb import drone_pkg::*; ();

	localparam int      CLKS_PER_US   = 4;
	localparam int      KP_SHIFT      = 2;
	localparam int      PWM_PERIOD_US = 2500;
	localparam int      CLK_NS        = 8;
	localparam int      NUM_ROWS      = 12;
	localparam longint  TIMEOUT_NS    = longint'(NUM_ROWS + 2) * 3 * PWM_PERIOD_US
		* CLKS_PER_US * CLK_NS; // Three PWM periods for each row plus two spare rows

	typedef struct packed {
		stick_t    sticks;
		attitude_t att;
		logic      rnd; // Attitude drawn at run time
	} row_t;

	logic      sys_clk;
	logic      resetn;
	logic [3:0] rc_pwm;   // 0 throttle, 1 yaw, 2 roll, 3 pitch
	attitude_t attitude;
	logic      att_valid;
	wire [3:0] motor_pwm; // Bit 0 is motor 1
	row_t      rows [NUM_ROWS];

	drone_ctrl #(
		.CLKS_PER_US(CLKS_PER_US),
		.KP_SHIFT(KP_SHIFT),
		.PWM_PERIOD_US(PWM_PERIOD_US)
	) drone_ctrl_inst (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.throttle_pwm(rc_pwm[0]),
		.yaw_pwm(rc_pwm[1]),
		.roll_pwm(rc_pwm[2]),
		.pitch_pwm(rc_pwm[3]),
		.attitude(attitude),
		.att_valid(att_valid),
		.motor_1_pwm(motor_pwm[0]),
		.motor_2_pwm(motor_pwm[1]),
		.motor_3_pwm(motor_pwm[2]),
		.motor_4_pwm(motor_pwm[3])
	);

	bind drone_ctrl drone_ctrl_assert assert_inst (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.us_tick(us_tick),
		.frame_valid(frame_valid),
		.rate_valid(rate_valid),
		.motors_valid(motors_valid),
		.motors(motors)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_NS / 2) sys_clk = ~sys_clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the motor pulses did not arrive in time");
		$display("Simulation failed");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		wait (drone_ctrl_inst.assert_inst.fail_count != 0);
		$display("A bound assertion on the datapath failed");
		$display("Simulation failed");
		$fatal(1, "Assertion failure");
	end

	function automatic row_t make_row(input int thr, input int yaw, input int roll,
		input int pitch, input int att_r, input int att_p, input logic rnd);
		row_t r;
		r.sticks = {8'(thr), 8'(yaw), 8'(roll), 8'(pitch)};
		r.att    = {16'(att_r), 16'(att_p), 16'sd0};
		r.rnd    = rnd;
		return r;
	endfunction

	// Motor rate from the control and X-frame mixing rules
	function automatic int expect_motor(input stick_t s, input attitude_t a, input int idx);
		int t;
		int r;
		int p;
		int y;
		int sum;
		t = 4 * int'(s.throttle);
		r = (int'(s.roll) - stick_center - int'($signed(a.roll))) >>> KP_SHIFT; // Floors
		p = (int'(s.pitch) - stick_center - int'($signed(a.pitch))) >>> KP_SHIFT;
		y = int'(s.yaw) - stick_center; // Measured yaw ignored
		case (idx)
			0:       sum = t + p + r - y;
			1:       sum = t + p - r + y;
			2:       sum = t - p - r - y;
			default: sum = t - p + r + y;
		endcase
		if (int'(s.throttle) < arm_min)
			return 0; // Disarmed
		if (sum < 0)
			return 0;
		return (sum > motor_max) ? motor_max : sum;
	endfunction

	task automatic check_value(input string name, input int actual, input int expected,
		input int tol);
		if (actual > expected + tol || actual < expected - tol) begin
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Simulation failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic drive_pulse(input int ch, input int start_us, input int width_us);
		@(posedge sys_clk);
		repeat (start_us * CLKS_PER_US) @(posedge sys_clk);
		#1 rc_pwm[ch] = 1'b1;
		repeat (width_us * CLKS_PER_US) @(posedge sys_clk);
		#1 rc_pwm[ch] = 1'b0;
	endtask

	// Stick v becomes a 1000 + 4v + 2 us pulse centered in its 4 us step
	task automatic send_frame(input stick_t s);
		int w[4];
		int last_end;
		int thr_start;
		w[0] = pulse_min_us + 4 * int'(s.throttle) + 2;
		w[1] = pulse_min_us + 4 * int'(s.yaw) + 2;
		w[2] = pulse_min_us + 4 * int'(s.roll) + 2;
		w[3] = pulse_min_us + 4 * int'(s.pitch) + 2;
		last_end = (w[1] > w[2]) ? w[1] : w[2];
		last_end = (w[3] > last_end) ? w[3] : last_end;
		thr_start = last_end + 8 - w[0]; // Throttle ends last and closes the frame
		if (thr_start < 0)
			thr_start = 0;
		fork
			drive_pulse(0, thr_start, w[0]);
			drive_pulse(1, 0, w[1]);
			drive_pulse(2, 0, w[2]);
			drive_pulse(3, 0, w[3]);
		join
	endtask

	// High time of each output over one fresh period in sys_clk cycles
	task automatic measure_pulses(output int hi[4]);
		foreach (hi[i])
			hi[i] = 0;
		do @(negedge sys_clk); while (motor_pwm[0] !== 1'b0); // Skip a pulse in progress
		do @(negedge sys_clk); while (motor_pwm[0] !== 1'b1); // Period start
		while (motor_pwm !== 4'b0000) begin
			for (int i = 0; i < 4; i++)
				if (motor_pwm[i] === 1'b1)
					hi[i]++;
			@(negedge sys_clk);
		end
	endtask

	task automatic check_motors(input stick_t s, input attitude_t a, input int row);
		int hi[4];
		measure_pulses(hi);
		for (int i = 0; i < 4; i++)
			check_value($sformatf("motor_%0d_pwm row %0d", i + 1, row), hi[i],
				(pulse_min_us + expect_motor(s, a, i)) * CLKS_PER_US, CLKS_PER_US);
	endtask

	initial begin
		row_t row;
		void'($urandom(32'h71ce));
		rc_pwm    = 4'b0000;
		attitude  = '0;
		att_valid = 1'b0;
		resetn    = 1'b0;
		// Throttle, yaw, roll, pitch, attitude roll and pitch
		rows[0]  = make_row(3, 200, 50, 180, 0, 0, 1'b0);      // Disarmed
		rows[1]  = make_row(100, 128, 128, 128, 0, 0, 1'b0);   // Hover, equal motors
		rows[2]  = make_row(100, 128, 168, 128, 0, 0, 1'b0);   // Roll right
		rows[3]  = make_row(100, 128, 128, 88, 0, 0, 1'b0);    // Pitch down
		rows[4]  = make_row(100, 160, 128, 128, 0, 0, 1'b0);   // Yaw rate, no shift
		rows[5]  = make_row(120, 128, 128, 128, 37, -22, 1'b0);
		rows[6]  = make_row(120, 128, 128, 128, -13, 7, 1'b0); // -7 >>> 2 is -2
		rows[7]  = make_row(255, 0, 255, 255, 0, 0, 1'b0);     // Saturates high
		rows[8]  = make_row(10, 255, 0, 0, 0, 0, 1'b0);        // Clamps at zero
		rows[9]  = make_row(150, 140, 120, 100, 0, 0, 1'b1);
		rows[10] = make_row(60, 110, 150, 135, 0, 0, 1'b1);
		rows[11] = make_row(200, 128, 128, 128, 0, 0, 1'b1);
		repeat (8) @(posedge sys_clk);
		#1 resetn = 1'b1;
		check_motors('0, '0, -1); // Idle pulses before any frame
		for (int r = 0; r < NUM_ROWS; r++) begin
			row = rows[r];
			if (row.rnd) begin
				row.att.roll  = 16'(int'($urandom % 401) - 200);
				row.att.pitch = 16'(int'($urandom % 401) - 200);
				row.att.yaw   = 16'($urandom); // Must have no effect
			end
			@(posedge sys_clk);
			#1 attitude = row.att;
			att_valid = 1'b1;
			@(posedge sys_clk);
			#1 att_valid = 1'b0;
			send_frame(row.sticks);
			repeat (4 * CLKS_PER_US) @(posedge sys_clk); // Pipeline done well before this
			check_motors(row.sticks, row.att, r);
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: drone_ctrl.f
verilog/drone_pkg.sv
verilog/us_tick.sv
verilog/pwm_receiver.sv
verilog/angle_controller.sv
verilog/motor_mixer.sv
verilog/pwm_generator.sv
verilog/drone_ctrl.sv
tb/drone_ctrl_assert.sv
tb/drone_ctrl_tb.sv

// File: Bender.yml
package:
  name: drone_ctrl

sources:
  - verilog/drone_pkg.sv
  - verilog/us_tick.sv
  - verilog/pwm_receiver.sv
  - verilog/angle_controller.sv
  - verilog/motor_mixer.sv
  - verilog/pwm_generator.sv
  - verilog/drone_ctrl.sv
  - target: test
    files:
      - tb/drone_ctrl_assert.sv
      - tb/drone_ctrl_tb.sv
